/* src/ram_cfg_pkg.sv */
`default_nettype none

package ram_cfg_pkg;

   // Geometry of one half block RAM, 16 Kbit without parity
   localparam int ADDR_BITS      = 14;                      // Bit address width
   localparam int LOG2_WORD      = 5;                       // Word is 2**5 bits
   localparam int WORD_BITS      = 1 << LOG2_WORD;          // 32 bit storage word
   localparam int WORD_ADDR_BITS = ADDR_BITS - LOG2_WORD;   // 9 bit word address
   localparam int NUM_WORDS      = 1 << WORD_ADDR_BITS;     // 512 words
   localparam int BYTE_BITS      = 8;                       // Bits per byte lane
   localparam int NUM_BYTES      = WORD_BITS / BYTE_BITS;   // 4 byte lanes

   // One enable per byte of the storage word
   typedef logic [NUM_BYTES-1:0] byte_en_t;

   // Spreads each byte enable over the 8 bits it covers
   function automatic logic [WORD_BITS-1:0] expand_byte_en(byte_en_t be);
      logic [WORD_BITS-1:0] bit_en;
      for (int b = 0; b < NUM_BYTES; b++) begin
         bit_en[b*BYTE_BITS +: BYTE_BITS] = {BYTE_BITS{be[b]}}; // Byte b to 8 bits
      end
      return bit_en;
   endfunction

endpackage

`default_nettype wire

/* src/ram_port_pkg.sv */
`default_nettype none

package ram_port_pkg;

   import ram_cfg_pkg::*;

   typedef logic [WORD_BITS-1:0]      word_t;      // One storage word
   typedef logic [WORD_ADDR_BITS-1:0] word_addr_t; // Selects one of 512 words
   typedef logic [LOG2_WORD-1:0]      lane_t;      // Bit offset inside a word

   // Full 14 bit bit address, split into word and lane
   // A narrow address shifted left by log2 of its width lands here
   typedef struct packed {
      word_addr_t word;  // Upper 9 bits
      lane_t      lane;  // Lower 5 bits, first bit of the field
   } bit_addr_t;

   // Write request from the write adapter to the storage
   typedef struct packed {
      logic       en;    // Write strobe for this wclk edge
      word_addr_t addr;  // Target word
      word_t      data;  // Data already moved to its lane
      word_t      mask;  // Bits that take the new data
   } ram_wr_t;

endpackage

`default_nettype wire

/* src/wr_width_port.sv */
`timescale 1ns/1ps
`default_nettype none

// Write side width adapter
// Maps a 1 to 32 bit write onto the 32 bit storage word
module wr_width_port
   import ram_cfg_pkg::*, ram_port_pkg::*;
#(
   parameter int LOG2WIDTH_WR = 5                          // Write width is 1 << LOG2WIDTH_WR
) (
   input  logic [ADDR_BITS-LOG2WIDTH_WR-1:0] waddr_i,      // Narrow write address
   input  logic                              we_i,         // Write enable
   input  byte_en_t                          web_i,        // Byte enables
   input  logic [(1 << LOG2WIDTH_WR)-1:0]    data_i,       // Narrow write data
   output ram_wr_t                           wr_o          // Request to the storage
);

   localparam int WIDTH_WR = 1 << LOG2WIDTH_WR;            // Write width in bits

   bit_addr_t wbit_addr;                                   // Address of first written bit
   word_t     lane_mask;                                   // Ones over the addressed lane
   word_t     byte_mask;                                   // Ones over the enabled bytes
   word_t     shifted_data;                                // data_i moved to its lane

   // Narrow address times width gives the bit address
   assign wbit_addr = bit_addr_t'(ADDR_BITS'(waddr_i) << LOG2WIDTH_WR);

   assign lane_mask    = word_t'({WIDTH_WR{1'b1}}) << wbit_addr.lane; // Field of this width
   assign byte_mask    = expand_byte_en(web_i);            // Byte enables as bit enables
   assign shifted_data = word_t'(data_i) << wbit_addr.lane;

   // A bit changes only inside the lane, in an enabled byte, with we_i high
   // Narrow writes still obey web_i, same as the 32 bit case
   always_comb begin
      wr_o.en   = we_i;                                    // Strobe follows we_i
      wr_o.addr = wbit_addr.word;                          // Upper 9 bits
      wr_o.data = shifted_data & lane_mask;                // Zero outside the lane
      wr_o.mask = we_i ? (lane_mask & byte_mask) : '0;     // No bits without we_i
   end

endmodule

`default_nettype wire

/* src/bram_array.sv */
`timescale 1ns/1ps
`default_nettype none

// 512 x 32 storage of the half block RAM
// Bit masked writes on wclk, asynchronous word read
module bram_array
   import ram_cfg_pkg::*, ram_port_pkg::*;
(
   input  logic       wclk,                                // Write clock
   input  ram_wr_t    wr_i,                                // Write request
   input  word_addr_t raddr_word_i,                        // Read word address
   output word_t      read_word_o                          // Word at raddr_word_i
);

   word_t mem [NUM_WORDS];                                 // Storage words

   // Power-up contents are zero, as in a BRAM without init data
   initial begin
      for (int i = 0; i < NUM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   // Masked read-modify-write of one word
   // Bits outside the mask keep their old value
   always_ff @(posedge wclk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= (mem[wr_i.addr] & ~wr_i.mask)   // Keep unmasked bits
                         | (wr_i.data & wr_i.mask);        // Take new masked bits
      end
   end

   // Read is combinational, the read port does the registering
   // A write at the same edge shows up only after that edge
   assign read_word_o = mem[raddr_word_i];

endmodule

`default_nettype wire

/* src/rd_width_port.sv */
`timescale 1ns/1ps
`default_nettype none

// Read side width adapter
// Lane select, read latch on ren_i, optional output register on regen_i
module rd_width_port
   import ram_port_pkg::*;
#(
   parameter int LOG2WIDTH_RD = 5,                         // Read width is 1 << LOG2WIDTH_RD
   parameter int REGISTERS    = 0                          // 1 adds the output register
) (
   input  logic                           rclk,            // Read clock
   input  logic                           rst_n_i,         // Sync reset, active low
   input  word_t                          read_word_i,     // Addressed storage word
   input  lane_t                          rlane_i,         // First bit of the field
   input  logic                           ren_i,           // Read enable
   input  logic                           regen_i,         // Output register enable
   output logic [(1 << LOG2WIDTH_RD)-1:0] data_o           // Read data
);

   localparam int WIDTH_RD = 1 << LOG2WIDTH_RD;            // Read width in bits

   word_t               aligned_word;                      // Field moved down to bit 0
   logic [WIDTH_RD-1:0] rd_field;                          // Field of the read width
   logic [WIDTH_RD-1:0] latch_q;                           // Read latch

   assign aligned_word = read_word_i >> rlane_i;           // Lane is width aligned
   assign rd_field     = aligned_word[WIDTH_RD-1:0];

   // First stage, one cycle after ren_i
   always_ff @(posedge rclk) begin
      if (!rst_n_i) begin
         latch_q <= '0;
      end else if (ren_i) begin
         latch_q <= rd_field;                              // Holds while ren_i is low
      end
   end

   generate
      if (REGISTERS != 0) begin : g_out_reg
         logic [WIDTH_RD-1:0] out_q;                       // Output register

         // Second stage, loads the latch when regen_i is high
         always_ff @(posedge rclk) begin
            if (!rst_n_i) begin
               out_q <= '0;
            end else if (regen_i) begin
               out_q <= latch_q;
            end
         end

         assign data_o = out_q;                            // Two cycle latency
      end else begin : g_no_out_reg
         assign data_o = latch_q;                          // One cycle latency
      end
   endgenerate

endmodule

`default_nettype wire

/* src/ram_var_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Half block RAM, 16 Kbit, independent write and read widths
module ram_var_top
   import ram_cfg_pkg::*, ram_port_pkg::*;
#(
   parameter int REGISTERS    = 0,                         // 1 for registered output
   parameter int LOG2WIDTH_WR = 5,                         // Write width 1 << LOG2WIDTH_WR
   parameter int LOG2WIDTH_RD = 5                          // Read width 1 << LOG2WIDTH_RD
) (
   input  logic                           wclk,            // Write clock
   input  logic                           rclk,            // Read clock
   input  logic                           rst_n_i,         // Sync reset, active low

   input  logic [ADDR_BITS-LOG2WIDTH_WR-1:0] waddr_i,      // Write address
   input  logic                           we_i,            // Write enable
   input  byte_en_t                       web_i,           // Write byte enables
   input  logic [(1 << LOG2WIDTH_WR)-1:0] data_i,          // Write data

   input  logic [ADDR_BITS-LOG2WIDTH_RD-1:0] raddr_i,      // Read address
   input  logic                           ren_i,           // Read enable
   input  logic                           regen_i,         // Output register enable
   output logic [(1 << LOG2WIDTH_RD)-1:0] data_o           // Read data
);

   ram_wr_t   wr_req;                                      // Write adapter to storage
   bit_addr_t rbit_addr;                                   // Read bit address
   word_t     read_word;                                   // Word under rbit_addr

   // Read address split, same scaling as the write side
   assign rbit_addr = bit_addr_t'(ADDR_BITS'(raddr_i) << LOG2WIDTH_RD);

   wr_width_port #(
      .LOG2WIDTH_WR (LOG2WIDTH_WR)
   ) i_wr_port (
      .waddr_i      (waddr_i),                             // Narrow address
      .we_i         (we_i),
      .web_i        (web_i),
      .data_i       (data_i),
      .wr_o         (wr_req)                               // Aligned masked request
   );

   bram_array i_array (
      .wclk         (wclk),
      .wr_i         (wr_req),
      .raddr_word_i (rbit_addr.word),                      // Upper 9 bits
      .read_word_o  (read_word)
   );

   rd_width_port #(
      .LOG2WIDTH_RD (LOG2WIDTH_RD),
      .REGISTERS    (REGISTERS)
   ) i_rd_port (
      .rclk         (rclk),
      .rst_n_i      (rst_n_i),
      .read_word_i  (read_word),
      .rlane_i      (rbit_addr.lane),                      // Lower 5 bits
      .ren_i        (ren_i),
      .regen_i      (regen_i),
      .data_o       (data_o)
   );

endmodule

`default_nettype wire

/* test/ram_var_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Assertions on the read output of ram_var_top
module ram_var_checker #(
   parameter int DATA_W = 32                               // Read width
) (
   input logic              clk_i,                         // Read clock
   input logic              rst_n_i,                       // Sync reset, active low
   input logic              regen_i,                       // Output register enable
   input logic [DATA_W-1:0] data_i                         // DUT data_o
);

   // Any edge in reset leaves a zero output behind
   property p_zero_after_reset;
      @(posedge clk_i) !rst_n_i |=> (data_i == '0);
   endproperty

   // Output register holds while regen_i is low
   property p_hold_without_regen;
      @(posedge clk_i) disable iff (!rst_n_i)
         (rst_n_i && !regen_i) |=> $stable(data_i);
   endproperty

   property p_no_unknown;
      @(posedge clk_i) disable iff (!rst_n_i)
         !$isunknown(data_i);                              // Storage powers up to zero
   endproperty

   a_zero_after_reset: assert property (p_zero_after_reset)
      else $error("data_o not zero after reset");

   a_hold_without_regen: assert property (p_hold_without_regen)
      else $error("data_o changed while regen_i was low");

   a_no_unknown: assert property (p_no_unknown)
      else $error("data_o has unknown bits");

endmodule

bind ram_var_top ram_var_checker #(
   .DATA_W  (1 << LOG2WIDTH_RD)
) i_checker (
   .clk_i   (rclk),
   .rst_n_i (rst_n_i),
   .regen_i (regen_i),
   .data_i  (data_o)
);

`default_nettype wire

/* test/tb_ram_var.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for ram_var_top with 8 bit writes, 16 bit reads and the output register
module tb_ram_var
   import ram_cfg_pkg::*;
();

   localparam int LOG2_WR      = 3;                        // 8 bit write port
   localparam int LOG2_RD      = 4;                        // 16 bit read port
   localparam int WR_W         = 1 << LOG2_WR;
   localparam int RD_W         = 1 << LOG2_RD;
   localparam int WA_W         = ADDR_BITS - LOG2_WR;      // 11 bit write address
   localparam int RA_W         = ADDR_BITS - LOG2_RD;      // 10 bit read address
   localparam int MEM_BITS     = 1 << ADDR_BITS;           // 16384 bits

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DLY    = 2;                        // Input skew after the rising edge
   localparam int RESET_CYCLES = 10;

   localparam int N_FILL = 64;                             // Full byte writes
   localparam int N_PART = 48;                             // Partial byte enable writes
   localparam int N_WRRD = 24;                             // Write then read pairs
   localparam int N_PIPE = 32;                             // Back to back reads
   localparam int N_HOLD = 8;                              // Writes under a held output

   localparam int TEST_CYCLES = RESET_CYCLES + 2*N_FILL + 2*N_PART + 2*N_WRRD
                              + N_PIPE + N_HOLD + 40;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * CLK_PERIOD;

   localparam logic [31:0] LFSR_SEED = 32'h7fe31edb;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;      // x^32 + x^22 + x^2 + x + 1

   logic            wclk;
   logic            rclk;
   logic            rst_n_i;
   logic [WA_W-1:0] waddr_i;
   logic            we_i;
   byte_en_t        web_i;
   logic [WR_W-1:0] data_i;
   logic [RA_W-1:0] raddr_i;
   logic            ren_i;
   logic            regen_i;
   logic [RD_W-1:0] data_o;

   bit              shadow [MEM_BITS];                     // Bit image of the storage
   logic [RD_W-1:0] exp_latch;                             // Expected read latch
   logic [RD_W-1:0] exp_out;                               // Expected data_o
   logic [RD_W-1:0] rd_field;
   logic            model_live;                            // Set once reset reached the model
   logic [31:0]     lfsr;
   int              errors;
   int              checks;
   logic [WA_W-1:0] written_q [$];                         // Addresses holding known data
   logic [WA_W-1:0] stim_waddr;
   logic [WR_W-1:0] stim_wdata;
   byte_en_t        stim_web;
   logic [RA_W-1:0] stim_raddr;
   logic [RD_W-1:0] held;

   ram_var_top #(
      .REGISTERS    (1),
      .LOG2WIDTH_WR (LOG2_WR),
      .LOG2WIDTH_RD (LOG2_RD)
   ) UUT (
      .wclk    (wclk),
      .rclk    (rclk),
      .rst_n_i (rst_n_i),
      .waddr_i (waddr_i),
      .we_i    (we_i),
      .web_i   (web_i),
      .data_i  (data_i),
      .raddr_i (raddr_i),
      .ren_i   (ren_i),
      .regen_i (regen_i),
      .data_o  (data_o)
   );

   // Both ports run from the same 50 MHz clock
   always #(CLK_PERIOD/2) begin
      wclk = ~wclk;
      rclk = ~rclk;
   end

   // One right shifting Galois step
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
   endfunction

   // n random bits with one LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr     = lfsr_next(lfsr);
         value[i] = lfsr[0];
      end
      return value;
   endfunction

   // One edge of the reference RAM
   // Read field is taken before the write of the same edge lands
   function automatic logic [RD_W-1:0] model_edge(
      input logic            we,
      input logic [WA_W-1:0] waddr,
      input byte_en_t        web,
      input logic [WR_W-1:0] wdata,
      input logic [RA_W-1:0] raddr
   );
      logic [RD_W-1:0] field;
      int              bit_pos;
      for (int j = 0; j < RD_W; j++) begin
         field[j] = shadow[int'(raddr) * RD_W + j];
      end
      if (we) begin
         for (int i = 0; i < WR_W; i++) begin
            bit_pos = int'(waddr) * WR_W + i;
            if (web[(bit_pos % WORD_BITS) / BYTE_BITS]) begin // Byte holding this bit
               shadow[bit_pos] = wdata[i];
            end
         end
      end
      return field;
   endfunction

   task automatic check_data_o(input logic [RD_W-1:0] expected);
      checks++;
      if (data_o !== expected) begin
         errors++;
         $display("[ERROR] %0d ns: data_o = 0x%h, expected 0x%h", $time, data_o, expected);
      end
   endtask

   // Inputs change DRIVE_DLY after the edge and take effect at the next one
   task automatic drive_cycle(
      input logic            we,
      input logic [WA_W-1:0] waddr,
      input byte_en_t        web,
      input logic [WR_W-1:0] wdata,
      input logic            ren,
      input logic [RA_W-1:0] raddr,
      input logic            regen
   );
      @(posedge rclk);
      #(DRIVE_DLY);
      we_i    = we;
      waddr_i = waddr;
      web_i   = web;
      data_i  = wdata;
      ren_i   = ren;
      raddr_i = raddr;
      regen_i = regen;
   endtask

   task automatic write_byte(
      input logic [WA_W-1:0] waddr,
      input byte_en_t        web,
      input logic [WR_W-1:0] wdata
   );
      drive_cycle(1'b1, waddr, web, wdata, 1'b0, '0, 1'b1);   // Keeps the pipe draining
   endtask

   task automatic read_field(input logic [RA_W-1:0] raddr);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, raddr, 1'b1);
   endtask

   task automatic idle_cycles(input int n, input logic regen);
      repeat (n) begin
         drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, regen);
      end
   endtask

   // Reference pipeline of latch and output register
   always @(posedge rclk) begin
      rd_field = model_edge(we_i, waddr_i, web_i, data_i, raddr_i);
      if (!rst_n_i) begin
         exp_latch  = '0;
         exp_out    = '0;
         model_live = 1'b1;
      end else begin
         if (regen_i) exp_out = exp_latch;                 // Old latch moves on first
         if (ren_i) exp_latch = rd_field;
      end
   end

   // data_o is settled at the falling edge
   always @(negedge rclk) begin
      if (model_live) begin
         check_data_o(exp_out);
      end
   end

   initial begin
      lfsr       = LFSR_SEED;
      errors     = 0;
      checks     = 0;
      model_live = 1'b0;
      exp_latch  = '0;
      exp_out    = '0;
      wclk       = 1'b0;
      rclk       = 1'b0;
      rst_n_i    = 1'b0;
      we_i       = 1'b0;
      waddr_i    = '0;
      web_i      = '0;
      data_i     = '0;
      ren_i      = 1'b0;
      raddr_i    = '0;
      regen_i    = 1'b0;

      repeat (RESET_CYCLES) @(posedge rclk);
      #(DRIVE_DLY);
      rst_n_i = 1'b1;

      idle_cycles(2, 1'b1);
      @(negedge rclk);
      check_data_o('0);                                    // Output cleared by reset

      // Random full byte writes read back as 16 bit fields
      for (int k = 0; k < N_FILL; k++) begin
         stim_waddr = WA_W'(rand_bits(WA_W));
         stim_wdata = WR_W'(rand_bits(WR_W));
         write_byte(stim_waddr, '1, stim_wdata);
         written_q.push_back(stim_waddr);
      end
      foreach (written_q[k]) begin
         read_field(RA_W'(written_q[k] >> 1));
      end
      idle_cycles(2, 1'b1);

      // Random byte enables over bytes that already hold data
      for (int k = 0; k < N_PART; k++) begin
         stim_web   = byte_en_t'(rand_bits(NUM_BYTES));
         stim_wdata = WR_W'(rand_bits(WR_W));
         write_byte(written_q[k], stim_web, stim_wdata);
      end
      for (int k = 0; k < N_PART; k++) begin
         read_field(RA_W'(written_q[k] >> 1));
      end
      idle_cycles(2, 1'b1);

      // Read at the edge right after the write
      for (int k = 0; k < N_WRRD; k++) begin
         stim_waddr = WA_W'(rand_bits(WA_W));
         stim_wdata = WR_W'(rand_bits(WR_W));
         write_byte(stim_waddr, '1, stim_wdata);
         read_field(RA_W'(stim_waddr >> 1));
      end

      // Same edge write and read gives the old field first and the new one next
      stim_waddr = written_q[1];
      stim_wdata = WR_W'(rand_bits(WR_W));
      drive_cycle(1'b1, stim_waddr, '1, stim_wdata, 1'b1, RA_W'(stim_waddr >> 1), 1'b1);
      read_field(RA_W'(stim_waddr >> 1));

      for (int k = 0; k < N_PIPE; k++) begin
         read_field(RA_W'(written_q[rand_bits(6) % written_q.size()] >> 1));
      end

      // Single read with regen_i one cycle behind ren_i
      stim_raddr = RA_W'(written_q[2] >> 1);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, stim_raddr, 1'b0);
      drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b1);
      idle_cycles(2, 1'b0);

      // Hold with both enables low while the word is rewritten
      stim_raddr = RA_W'(written_q[3] >> 1);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, stim_raddr, 1'b0);
      drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b1);
      idle_cycles(3, 1'b0);
      @(negedge rclk);
      held = exp_out;
      for (int k = 0; k < N_HOLD; k++) begin
         stim_wdata = WR_W'(rand_bits(WR_W));
         drive_cycle(1'b1, WA_W'({stim_raddr, k[0]}), '1, stim_wdata, 1'b0, '0, 1'b0);
         @(negedge rclk);
         check_data_o(held);
      end
      read_field(stim_raddr);                              // New contents come through
      idle_cycles(3, 1'b1);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Watchdog sized from the cycle count of all tests
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
src/ram_cfg_pkg.sv
src/ram_port_pkg.sv
src/wr_width_port.sv
src/bram_array.sv
src/rd_width_port.sv
src/ram_var_top.sv
test/ram_var_checker.sv
test/tb_ram_var.sv

/* Bender.yml */
package:
  name: ram_var

# Packages first, then the modules bottom up
sources:
  - files:
      - src/ram_cfg_pkg.sv
      - src/ram_port_pkg.sv
      - src/wr_width_port.sv
      - src/bram_array.sv
      - src/rd_width_port.sv
      - src/ram_var_top.sv

  # Simulation only, top module tb_ram_var
  - target: test
    files:
      - test/ram_var_checker.sv
      - test/tb_ram_var.sv
